//--- Bender.yml
package:
  name: mwc_cntl

sources:
  - files:
      - hdl/mwc_pkg.sv
      - hdl/mwc_fifo.sv
      - hdl/mwc_ingress.sv
      - hdl/mwc_packet_arbiter.sv
      - hdl/mwc_write_issue.sv
      - hdl/mwc_cntl.sv
  - target: test
    files:
      - verif/mwc_cntl_tb.sv

//--- hdl/mwc_cntl.sv
// ----------------------------
// Memory write controller top, noc and rdp sources
// Source to memory latency varies with arbitration and stalls
// Threshold must leave three free entries for beats in flight
// ----------------------------

`timescale 1ns/1ns

module mwc_cntl #(
    parameter int depth                 = 8,
    parameter int almost_full_threshold = 5
) (
    input  logic              clk,
    input  logic              arst_n,
    // Network-on-chip source
    input  logic              noc_valid,
    input  mwc_pkg::cntl_t    noc_cntl,
    input  mwc_pkg::data_t    noc_data,
    output logic              noc_ready,
    // Return data processor source
    input  logic              rdp_valid,
    input  mwc_pkg::cntl_t    rdp_cntl,
    input  mwc_pkg::data_t    rdp_data,
    output logic              rdp_ready,
    // Main memory controller
    output logic              mmc_valid,
    output mwc_pkg::cntl_t    mmc_cntl,
    output mwc_pkg::channel_t mmc_channel,
    output mwc_pkg::bank_t    mmc_bank,
    output mwc_pkg::page_t    mmc_page,
    output mwc_pkg::word_t    mmc_word,
    output mwc_pkg::data_t    mmc_data,
    input  logic              mmc_ready
);

    // FIFO heads
    logic           noc_head_valid;
    mwc_pkg::beat_t noc_head_beat;
    logic           noc_pop;
    logic           rdp_head_valid;
    mwc_pkg::beat_t rdp_head_beat;
    logic           rdp_pop;
    // Arbiter to issuer
    logic           beat_valid;
    mwc_pkg::beat_t beat;
    logic           beat_accept;

    // ----------------------------
    // Ingress paths
    // ----------------------------
    mwc_ingress #(
        .depth                 (depth),
        .almost_full_threshold (almost_full_threshold)
    ) u_noc_ingress (
        .clk        (clk),
        .arst_n     (arst_n),
        .valid      (noc_valid),
        .cntl       (noc_cntl),
        .data       (noc_data),
        .ready      (noc_ready),
        .head_valid (noc_head_valid),
        .head_beat  (noc_head_beat),
        .pop        (noc_pop)
    );

    mwc_ingress #(
        .depth                 (depth),
        .almost_full_threshold (almost_full_threshold)
    ) u_rdp_ingress (
        .clk        (clk),
        .arst_n     (arst_n),
        .valid      (rdp_valid),
        .cntl       (rdp_cntl),
        .data       (rdp_data),
        .ready      (rdp_ready),
        .head_valid (rdp_head_valid),
        .head_beat  (rdp_head_beat),
        .pop        (rdp_pop)
    );

    // Whole packets, round robin
    mwc_packet_arbiter u_arbiter (
        .clk            (clk),
        .arst_n         (arst_n),
        .noc_head_valid (noc_head_valid),
        .noc_head_beat  (noc_head_beat),
        .rdp_head_valid (rdp_head_valid),
        .rdp_head_beat  (rdp_head_beat),
        .noc_pop        (noc_pop),
        .rdp_pop        (rdp_pop),
        .beat_valid     (beat_valid),
        .beat           (beat),
        .beat_accept    (beat_accept)
    );

    mwc_write_issue u_write_issue (
        .clk         (clk),
        .arst_n      (arst_n),
        .beat_valid  (beat_valid),
        .beat        (beat),
        .beat_accept (beat_accept),
        .mmc_valid   (mmc_valid),
        .mmc_cntl    (mmc_cntl),
        .mmc_channel (mmc_channel),
        .mmc_bank    (mmc_bank),
        .mmc_page    (mmc_page),
        .mmc_word    (mmc_word),
        .mmc_data    (mmc_data),
        .mmc_ready   (mmc_ready)
    );

endmodule

//--- hdl/mwc_fifo.sv
// ----------------------------
// Circular buffer FIFO, head visible with no read latency
// almost_full is combinational from the count
// Writer must not push when full unless the head is popped
// ----------------------------

`timescale 1ns/1ns

module mwc_fifo #(
    parameter int depth                 = 8,
    parameter int almost_full_threshold = 5,
    parameter int width                 = 34
) (
    input  logic             clk,
    input  logic             arst_n,
    // Write side
    input  logic             write,
    input  logic [width-1:0] write_data,
    // Read side, first word falls through
    input  logic             read,
    output logic             valid,
    output logic [width-1:0] read_data,
    // Status
    output logic             almost_full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             full;
    logic             do_write;
    logic             do_read;

    assign full     = (count == cnt_w'(depth));
    assign valid    = (count != '0);
    assign do_write = write;
    assign do_read  = read && valid;

    // Head straight out of the array
    assign read_data   = mem[rd_ptr];
    assign almost_full = (count >= cnt_w'(almost_full_threshold));

    // ----------------------------
    // Storage, no reset needed
    // ----------------------------
    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            mem[wr_ptr] <= write_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_write)
            begin
                // Wrap for non power-of-two depths too
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read)
            begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_write && !do_read)
            begin
                count <= count + 1'b1;
            end
            else if (do_read && !do_write)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // ----------------------------
    // Overflow and underflow
    // ----------------------------
    a_no_overflow : assert property (@(posedge clk) disable iff (!arst_n)
        write |-> (!full || read));

    a_no_underflow : assert property (@(posedge clk) disable iff (!arst_n)
        read |-> valid);

endmodule

//--- hdl/mwc_ingress.sv
// ----------------------------
// One source port: input register, FIFO, registered ready
// Ready is credit only, every valid beat is stored
// Sender must stop within two cycles of ready falling
// ----------------------------

`timescale 1ns/1ns

module mwc_ingress #(
    parameter int depth                 = 8,
    parameter int almost_full_threshold = 5
) (
    input  logic            clk,
    input  logic            arst_n,
    // Source port
    input  logic            valid,
    input  mwc_pkg::cntl_t  cntl,
    input  mwc_pkg::data_t  data,
    output logic            ready,
    // Towards the arbiter
    output logic            head_valid,
    output mwc_pkg::beat_t  head_beat,
    input  logic            pop
);

    logic           valid_q;
    mwc_pkg::cntl_t cntl_q;
    mwc_pkg::data_t data_q;
    logic           almost_full;

    // ----------------------------
    // Input register stage
    // ----------------------------
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= valid;
        end
    end

    // Payload follows valid, no reset
    always_ff @(posedge clk)
    begin
        cntl_q <= cntl;
        data_q <= data;
    end

    // Ready lags FIFO state by one cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ready <= 1'b0;
        end
        else
        begin
            ready <= ~almost_full;
        end
    end

    // Stored beat is {cntl, data}
    mwc_fifo #(
        .depth                 (depth),
        .almost_full_threshold (almost_full_threshold),
        .width                 (mwc_pkg::beat_w)
    ) u_fifo (
        .clk         (clk),
        .arst_n      (arst_n),
        .write       (valid_q),
        .write_data  ({cntl_q, data_q}),
        .read        (pop),
        .valid       (head_valid),
        .read_data   (head_beat),
        .almost_full (almost_full)
    );

endmodule

//--- hdl/mwc_packet_arbiter.sv
// ----------------------------
// Round-robin packet arbiter between noc and rdp FIFOs
// Grant is held from the first beat to the accepted end beat
// ----------------------------

`timescale 1ns/1ns

module mwc_packet_arbiter (
    input  logic           clk,
    input  logic           arst_n,
    // Ingress heads
    input  logic           noc_head_valid,
    input  mwc_pkg::beat_t noc_head_beat,
    input  logic           rdp_head_valid,
    input  mwc_pkg::beat_t rdp_head_beat,
    output logic           noc_pop,
    output logic           rdp_pop,
    // Towards the write issuer
    output logic           beat_valid,
    output mwc_pkg::beat_t beat,
    input  logic           beat_accept
);

    // Grant encoding: 0 noc, 1 rdp
    logic           grant;
    logic           grant_q;
    logic           open_q;
    logic           last_rdp;
    logic           accept;
    logic           is_end;
    mwc_pkg::cntl_t beat_cntl;

    // ----------------------------
    // Grant selection
    // ----------------------------
    always_comb
    begin
        if (open_q)
        begin
            grant = grant_q;
        end
        else if (noc_head_valid && rdp_head_valid)
        begin
            // Both waiting, take the other one
            grant = ~last_rdp;
        end
        else
        begin
            grant = rdp_head_valid;
        end
    end

    assign beat_valid = grant ? rdp_head_valid : noc_head_valid;
    assign beat       = grant ? rdp_head_beat : noc_head_beat;
    assign accept     = beat_valid && beat_accept;
    assign noc_pop    = accept && !grant;
    assign rdp_pop    = accept && grant;

    assign beat_cntl = beat[mwc_pkg::beat_cntl_lsb +: mwc_pkg::cntl_w];
    assign is_end    = (beat_cntl == mwc_pkg::cntl_eom) ||
                       (beat_cntl == mwc_pkg::cntl_som_eom);

    // Packet tracking
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            open_q   <= 1'b0;
            grant_q  <= 1'b0;
            // Noc goes first on a tie after reset
            last_rdp <= 1'b1;
        end
        else if (accept)
        begin
            if (is_end)
            begin
                open_q   <= 1'b0;
                last_rdp <= grant;
            end
            else
            begin
                open_q  <= 1'b1;
                grant_q <= grant;
            end
        end
    end

    // Held source shows only middle and end beats while a packet is open
    a_grant_held : assert property (@(posedge clk) disable iff (!arst_n)
        (open_q && beat_valid) |-> ((beat_cntl == mwc_pkg::cntl_mom) ||
                                    (beat_cntl == mwc_pkg::cntl_eom)));

endmodule

//--- hdl/mwc_pkg.sv
// ----------------------------
// Shared widths and frame codes for the memory write controller
// A stored beat is {cntl, data}, cntl in the top two bits
// Descriptor fields sit in the low 24 bits of a start beat
// ----------------------------

package mwc_pkg;

    // ----------------------------
    // Widths
    // ----------------------------
    localparam int data_w    = 32;
    localparam int cntl_w    = 2;
    localparam int channel_w = 2;
    localparam int bank_w    = 3;
    localparam int page_w    = 12;
    localparam int word_w    = 7;
    localparam int beat_w    = cntl_w + data_w;

    // Vectors with a meaning
    typedef logic [data_w-1:0]    data_t;
    typedef logic [cntl_w-1:0]    cntl_t;
    typedef logic [channel_w-1:0] channel_t;
    typedef logic [bank_w-1:0]    bank_t;
    typedef logic [page_w-1:0]    page_t;
    typedef logic [word_w-1:0]    word_t;
    typedef logic [beat_w-1:0]    beat_t;

    // ----------------------------
    // Frame control codes
    // ----------------------------
    localparam cntl_t cntl_som_eom = 2'b00;
    localparam cntl_t cntl_som     = 2'b01;
    localparam cntl_t cntl_mom     = 2'b10;
    localparam cntl_t cntl_eom     = 2'b11;

    // Descriptor layout, word lowest
    localparam int desc_word_lsb    = 0;
    localparam int desc_page_lsb    = desc_word_lsb + word_w;
    localparam int desc_bank_lsb    = desc_page_lsb + page_w;
    localparam int desc_channel_lsb = desc_bank_lsb + bank_w;

    // Control field position inside a stored beat
    localparam int beat_cntl_lsb = data_w;

endpackage

//--- hdl/mwc_write_issue.sv
// ----------------------------
// Descriptor capture and one memory write per data beat
// Next beat is taken only when the current write transfers
// Word address wraps modulo 2^word_w inside a page
// ----------------------------

`timescale 1ns/1ns

module mwc_write_issue (
    input  logic              clk,
    input  logic              arst_n,
    // From the arbiter
    input  logic              beat_valid,
    input  mwc_pkg::beat_t    beat,
    output logic              beat_accept,
    // Memory controller port
    output logic              mmc_valid,
    output mwc_pkg::cntl_t    mmc_cntl,
    output mwc_pkg::channel_t mmc_channel,
    output mwc_pkg::bank_t    mmc_bank,
    output mwc_pkg::page_t    mmc_page,
    output mwc_pkg::word_t    mmc_word,
    output mwc_pkg::data_t    mmc_data,
    input  logic              mmc_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_data,
        st_issue
    } state_t;

    state_t            state;
    mwc_pkg::cntl_t    beat_cntl;
    mwc_pkg::data_t    beat_data;
    logic              is_end;
    logic              take_desc;
    logic              take_data;
    mwc_pkg::cntl_t    write_cntl;
    // Captured descriptor, word is the next address
    mwc_pkg::channel_t channel_q;
    mwc_pkg::bank_t    bank_q;
    mwc_pkg::page_t    page_q;
    mwc_pkg::word_t    word_q;
    logic              first_q;
    logic              last_q;

    assign beat_cntl = beat[mwc_pkg::beat_cntl_lsb +: mwc_pkg::cntl_w];
    assign beat_data = beat[mwc_pkg::data_w-1:0];
    assign is_end    = (beat_cntl == mwc_pkg::cntl_eom) ||
                       (beat_cntl == mwc_pkg::cntl_som_eom);

    // ----------------------------
    // Accept rules
    // ----------------------------
    assign take_desc   = beat_valid && (state == st_idle);
    // In issue, a new beat rides on the transfer cycle
    assign take_data   = beat_valid && ((state == st_data) ||
                         ((state == st_issue) && mmc_ready && !last_q));
    assign beat_accept = take_desc || take_data;

    // Marking from position in packet and end code
    always_comb
    begin
        case ({first_q, is_end})
            2'b11:   write_cntl = mwc_pkg::cntl_som_eom;
            2'b10:   write_cntl = mwc_pkg::cntl_som;
            2'b01:   write_cntl = mwc_pkg::cntl_eom;
            default: write_cntl = mwc_pkg::cntl_mom;
        endcase
    end

    // Descriptor fields, only loaded from a start beat
    always_ff @(posedge clk)
    begin
        if (take_desc && (beat_cntl == mwc_pkg::cntl_som))
        begin
            channel_q <= beat_data[mwc_pkg::desc_channel_lsb +: mwc_pkg::channel_w];
            bank_q    <= beat_data[mwc_pkg::desc_bank_lsb +: mwc_pkg::bank_w];
            page_q    <= beat_data[mwc_pkg::desc_page_lsb +: mwc_pkg::page_w];
        end
    end

    // ----------------------------
    // FSM and memory port registers
    // ----------------------------
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state       <= st_idle;
            first_q     <= 1'b0;
            last_q      <= 1'b0;
            word_q      <= '0;
            mmc_valid   <= 1'b0;
            mmc_cntl    <= '0;
            mmc_channel <= '0;
            mmc_bank    <= '0;
            mmc_page    <= '0;
            mmc_word    <= '0;
            mmc_data    <= '0;
        end
        else if (take_data)
        begin
            mmc_valid   <= 1'b1;
            mmc_cntl    <= write_cntl;
            mmc_channel <= channel_q;
            mmc_bank    <= bank_q;
            mmc_page    <= page_q;
            mmc_word    <= word_q;
            mmc_data    <= beat_data;
            // Natural wrap at 2^word_w
            word_q      <= word_q + 1'b1;
            first_q     <= 1'b0;
            last_q      <= is_end;
            state       <= st_issue;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    // Start-and-end descriptor: nothing to write
                    if (take_desc && (beat_cntl == mwc_pkg::cntl_som))
                    begin
                        word_q  <= beat_data[mwc_pkg::desc_word_lsb +: mwc_pkg::word_w];
                        first_q <= 1'b1;
                        state   <= st_data;
                    end
                end
                st_issue:
                begin
                    if (mmc_ready)
                    begin
                        mmc_valid <= 1'b0;
                        state     <= last_q ? st_idle : st_data;
                    end
                end
                default:
                begin
                    state <= state;
                end
            endcase
        end
    end

    // Framing error, start code inside a packet
    a_no_start_in_data : assert property (@(posedge clk) disable iff (!arst_n)
        take_data |-> !((beat_cntl == mwc_pkg::cntl_som) ||
                        (beat_cntl == mwc_pkg::cntl_som_eom)));

    // Stalled write holds the whole port
    a_mmc_hold : assert property (@(posedge clk) disable iff (!arst_n)
        (mmc_valid && !mmc_ready) |=> (mmc_valid && $stable({mmc_cntl, mmc_channel,
        mmc_bank, mmc_page, mmc_word, mmc_data})));

endmodule

//--- mwc_cntl.f
hdl/mwc_pkg.sv
hdl/mwc_fifo.sv
hdl/mwc_ingress.sv
hdl/mwc_packet_arbiter.sv
hdl/mwc_write_issue.sv
hdl/mwc_cntl.sv
verif/mwc_cntl_tb.sv

//--- verif/mwc_cntl_tb.sv
// ----------------------------
// Testbench for the memory write controller
// Inputs move 2 ns after the rising edge, outputs sampled on the edge
// Expected writes queued per source when a data beat is sent
// ----------------------------

`timescale 1ns/1ns

module mwc_cntl_tb;

    localparam int period = 20;
    localparam int wr_w   = 58;
    // Packed write: {cntl, channel, bank, page, word, data}
    typedef logic [wr_w-1:0] write_t;

    logic              clk;
    logic              arst_n;
    logic              noc_valid;
    mwc_pkg::cntl_t    noc_cntl;
    mwc_pkg::data_t    noc_data;
    logic              noc_ready;
    logic              rdp_valid;
    mwc_pkg::cntl_t    rdp_cntl;
    mwc_pkg::data_t    rdp_data;
    logic              rdp_ready;
    logic              mmc_valid;
    mwc_pkg::cntl_t    mmc_cntl;
    mwc_pkg::channel_t mmc_channel;
    mwc_pkg::bank_t    mmc_bank;
    mwc_pkg::page_t    mmc_page;
    mwc_pkg::word_t    mmc_word;
    mwc_pkg::data_t    mmc_data;
    logic              mmc_ready;

    integer seed = 32'hec08;
    int     errors;
    int     checks;
    int     sent_beats;
    // 0 always ready, 1 random stalls, 2 held low
    int     ready_mode;
    string  test_name;
    write_t noc_exp[$];
    write_t rdp_exp[$];
    // Scoreboard state
    logic   in_packet;
    logic   pkt_src;
    logic   have_prev;
    logic   prev_src;
    logic   other_waiting;
    logic   rr_check;
    logic   stalled;
    write_t held_write;

    mwc_cntl #(
        .depth                 (8),
        .almost_full_threshold (5)
    ) u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .noc_valid   (noc_valid),
        .noc_cntl    (noc_cntl),
        .noc_data    (noc_data),
        .noc_ready   (noc_ready),
        .rdp_valid   (rdp_valid),
        .rdp_cntl    (rdp_cntl),
        .rdp_data    (rdp_data),
        .rdp_ready   (rdp_ready),
        .mmc_valid   (mmc_valid),
        .mmc_cntl    (mmc_cntl),
        .mmc_channel (mmc_channel),
        .mmc_bank    (mmc_bank),
        .mmc_page    (mmc_page),
        .mmc_word    (mmc_word),
        .mmc_data    (mmc_data),
        .mmc_ready   (mmc_ready)
    );

    // ----------------------------
    // Clock and memory side ready
    // ----------------------------
    always #(period / 2) clk = ~clk;

    always @(posedge clk)
    begin
        #2;
        case (ready_mode)
            0:       mmc_ready = 1'b1;
            // Roughly one stall in four
            1:       mmc_ready = (($random(seed) & 3) != 0);
            default: mmc_ready = 1'b0;
        endcase
    end

    // Expected write for data beat idx of a packet with n_data data beats
    function automatic write_t expected_write(input mwc_pkg::data_t desc, input int idx,
                                              input int n_data, input mwc_pkg::data_t data);
        mwc_pkg::cntl_t c;
        mwc_pkg::word_t w;
        if (n_data == 1)
            c = mwc_pkg::cntl_som_eom;
        else if (idx == 0)
            c = mwc_pkg::cntl_som;
        else if (idx == n_data - 1)
            c = mwc_pkg::cntl_eom;
        else
            c = mwc_pkg::cntl_mom;
        // Word wraps inside the page
        w = 7'((int'(desc[6:0]) + idx) % 128);
        return {c, desc[23:22], desc[21:19], desc[18:7], w, data};
    endfunction

    function automatic write_t port_value();
        return {mmc_cntl, mmc_channel, mmc_bank, mmc_page, mmc_word, mmc_data};
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] exp,
                                   input logic [63:0] act);
        errors++;
        $display("FAIL %s %s: expected %h actual %h", test_name, what, exp, act);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR in %s: %s", test_name, msg);
    endtask

    // ----------------------------
    // Source side drivers
    // ----------------------------
    task automatic drive_beat(input bit src, input logic v, input mwc_pkg::cntl_t c,
                              input mwc_pkg::data_t d);
        if (src)
        begin
            rdp_valid = v;
            rdp_cntl  = c;
            rdp_data  = d;
        end
        else
        begin
            noc_valid = v;
            noc_cntl  = c;
            noc_data  = d;
        end
    endtask

    // Descriptor beat, then n_data data beats, pausing while ready is low
    task automatic send_packet(input bit src, input mwc_pkg::data_t desc, input int n_data);
        mwc_pkg::cntl_t c;
        mwc_pkg::data_t d;
        for (int i = 0; i <= n_data; i++)
        begin
            while (!(src ? rdp_ready : noc_ready))
            begin
                drive_beat(src, 1'b0, '0, '0);
                @(posedge clk);
                #2;
            end
            if (i == 0)
            begin
                c = (n_data == 0) ? mwc_pkg::cntl_som_eom : mwc_pkg::cntl_som;
                d = desc;
            end
            else
            begin
                c = (i == n_data) ? mwc_pkg::cntl_eom : mwc_pkg::cntl_mom;
                d = $random(seed);
                if (src)
                    rdp_exp.push_back(expected_write(desc, i - 1, n_data, d));
                else
                    noc_exp.push_back(expected_write(desc, i - 1, n_data, d));
            end
            drive_beat(src, 1'b1, c, d);
            sent_beats++;
            @(posedge clk);
            #2;
        end
        drive_beat(src, 1'b0, '0, '0);
    endtask

    // Lengths 0 to 6 data beats
    task automatic send_random(input bit src, input int count);
        repeat (count)
            send_packet(src, $random(seed), ($random(seed) & 32'h7fffffff) % 7);
    endtask

    task automatic set_ready_mode(input int m);
        @(posedge clk);
        ready_mode = m;
        #2;
    endtask

    // Wait until every queued write has been seen, then a quiet tail
    task automatic drain();
        while (noc_exp.size() > 0 || rdp_exp.size() > 0 || mmc_valid)
            @(posedge clk);
        repeat (20) @(posedge clk);
        #2;
        if (in_packet)
            report_error("a packet was still open after all writes were seen");
    endtask

    // ----------------------------
    // Scoreboard
    // ----------------------------
    task automatic check_write(input write_t actual);
        logic   end_write;
        write_t noc_head;
        write_t rdp_head;
        checks++;
        end_write = (actual[57:56] == mwc_pkg::cntl_eom) ||
                    (actual[57:56] == mwc_pkg::cntl_som_eom);
        noc_head  = (noc_exp.size() > 0) ? noc_exp[0] : 'x;
        rdp_head  = (rdp_exp.size() > 0) ? rdp_exp[0] : 'x;
        if (!in_packet)
        begin
            if (noc_exp.size() > 0 && noc_head === actual)
                pkt_src = 1'b0;
            else if (rdp_exp.size() > 0 && rdp_head === actual)
                pkt_src = 1'b1;
            else
            begin
                errors++;
                $display("FAIL %s first write: expected %h or %h actual %h",
                         test_name, noc_head, rdp_head, actual);
                return;
            end
            if (rr_check && have_prev && other_waiting && (pkt_src == prev_src))
                report_error("same source served twice while the other had a packet");
        end
        else if ((pkt_src ? rdp_exp.size() : noc_exp.size()) == 0)
        begin
            report_error("write seen with no pending write for the open packet");
            return;
        end
        else if ((pkt_src ? rdp_head : noc_head) !== actual)
        begin
            report_mismatch("write", pkt_src ? rdp_head : noc_head, actual);
        end
        if (pkt_src)
            void'(rdp_exp.pop_front());
        else
            void'(noc_exp.pop_front());
        in_packet = !end_write;
        if (end_write)
        begin
            have_prev     = 1'b1;
            prev_src      = pkt_src;
            other_waiting = pkt_src ? (noc_exp.size() > 0) : (rdp_exp.size() > 0);
        end
    endtask

    always @(posedge clk)
    begin : scoreboard
        write_t actual;
        actual = port_value();
        if (arst_n)
        begin
            // Stalled write must hold every field
            if (stalled)
            begin
                checks++;
                if (!mmc_valid || actual !== held_write)
                    report_mismatch("held write", held_write, mmc_valid ? actual : 'x);
            end
            stalled    = mmc_valid && !mmc_ready;
            held_write = actual;
            if (mmc_valid && mmc_ready)
                check_write(actual);
        end
    end

    // Limit grows with the beats sent
    initial
    begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < 200 * sent_beats + 2000)
        begin
            @(posedge clk);
            cycles++;
        end
        errors++;
        $display("Timeout after %0d cycles in %s, writes still pending", cycles, test_name);
        $display("Checks %0d, errors %0d", checks, errors);
        $display("TEST FAIL");
        $finish;
    end

    // ----------------------------
    // Test sequence
    // ----------------------------
    initial
    begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        mmc_ready  = 1'b0;
        ready_mode = 0;
        errors     = 0;
        checks     = 0;
        sent_beats = 0;
        in_packet  = 1'b0;
        pkt_src    = 1'b0;
        have_prev  = 1'b0;
        prev_src   = 1'b0;
        rr_check   = 1'b0;
        stalled    = 1'b0;
        held_write = '0;
        drive_beat(1'b0, 1'b0, '0, '0);
        drive_beat(1'b1, 1'b0, '0, '0);

        test_name = "reset";
        repeat (8) @(posedge clk);
        #2;
        checks += 2;
        if ({noc_ready, rdp_ready, mmc_valid} !== 3'b000)
            report_mismatch("ready and valid in reset", 0, {noc_ready, rdp_ready, mmc_valid});
        if (port_value() !== '0)
            report_mismatch("memory outputs in reset", 0, port_value());
        arst_n = 1'b1;
        #1;
        checks++;
        if ({noc_ready, rdp_ready, mmc_valid} !== 3'b000)
            report_mismatch("outputs at release", 0, {noc_ready, rdp_ready, mmc_valid});
        @(posedge clk);
        #2;
        checks++;
        if ({noc_ready, rdp_ready, mmc_valid} !== 3'b110)
            report_mismatch("first cycle after release", 3'b110,
                            {noc_ready, rdp_ready, mmc_valid});

        // Word 0x7d with 6 data beats crosses the wrap
        test_name = "noc_single";
        send_packet(1'b0, {8'h00, 2'd1, 3'd5, 12'habc, 7'h7d}, 6);
        send_packet(1'b0, $random(seed), 0);
        send_random(1'b0, 4);
        drain();

        test_name = "rdp_single";
        send_packet(1'b1, {8'hff, 2'd3, 3'd2, 12'h123, 7'h7f}, 3);
        send_packet(1'b1, $random(seed), 0);
        send_random(1'b1, 4);
        drain();

        test_name = "concurrent";
        fork
            send_random(1'b0, 8);
            send_random(1'b1, 8);
        join
        drain();

        // Both FIFOs loaded before the memory side opens
        test_name = "round_robin";
        set_ready_mode(2);
        fork
            repeat (2) send_packet(1'b0, $random(seed), 1);
            repeat (2) send_packet(1'b1, $random(seed), 1);
        join
        repeat (4) @(posedge clk);
        have_prev = 1'b0;
        rr_check  = 1'b1;
        set_ready_mode(0);
        drain();
        rr_check = 1'b0;

        test_name = "mmc_stall_random";
        set_ready_mode(1);
        fork
            send_random(1'b0, 10);
            send_random(1'b1, 10);
        join
        drain();
        set_ready_mode(0);

        test_name = "mmc_hold_40";
        set_ready_mode(2);
        fork
            repeat (3) send_packet(1'b0, $random(seed), 6);
            repeat (3) send_packet(1'b1, $random(seed), 6);
            begin
                repeat (40) @(posedge clk);
                #2;
                checks++;
                if ({noc_ready, rdp_ready} !== 2'b00)
                    report_mismatch("source ready under stall", 2'b00, {noc_ready, rdp_ready});
                set_ready_mode(0);
            end
        join
        drain();

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule
